// File: Bender.yml
package:
  name: line_scrambler

sources:
  - include_dirs:
      - .
    files:
      - scrambler_pkg.sv
      - cut_position_interpolator.sv
      - line_rotator.sv
      - cut_key_generator.sv
      - line_scrambler_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - line_scrambler_checker.sv
      - line_scrambler_tb.sv

// File: cut_key_generator.sv
`timescale 1ns/100ps

module cut_key_generator import scrambler_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  video_sample_t video_in,
    input  logic [15:0]   seed,
    output logic [7:0]    raw_cut,
    output logic [7:0]    raw_cut_delayed
);

    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic        feedback;
    logic [7:0]  cut_q;      // cut of the line in progress
    logic        prev_h;
    logic        line_start; // falling edge of h

    always_comb begin
        line_start = prev_h & ~video_in.h;
        feedback   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16+x^14+x^13+x^11

        if (video_in.v) begin
            lfsr_next = seed; // every frame restarts from the same key
        end else if (line_start) begin
            lfsr_next = {lfsr[14:0], feedback};
        end else begin
            lfsr_next = lfsr;
        end

        // The new cut is already valid on the edge clock, so sample 0 uses it too
        raw_cut = line_start ? lfsr_next[7:0] : cut_q;
    end

    // Registered copy trails raw_cut by one clock at the edge,
    // which matches the one clock delayed stream into the descrambler
    assign raw_cut_delayed = cut_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr   <= seed; // an all-zero state would lock the LFSR
            cut_q  <= '0;
            prev_h <= video_in.h;
        end else begin
            lfsr   <= lfsr_next;
            prev_h <= video_in.h;
            if (line_start) begin
                cut_q <= lfsr_next[7:0]; // held for the rest of the line
            end
        end
    end

endmodule

// File: cut_position_interpolator.sv
`timescale 1ns/100ps

module cut_position_interpolator import scrambler_pkg::*; (
    input  logic [7:0] raw_cut_position,
    output line_addr_t cut_position
);

    line_addr_t raw_times_five; // raw * 5, at most 1275
    line_addr_t eighth;         // a further raw * 5 / 8

    // The full range of 255 maps to 1434, short of the line end without a divider
    always_comb begin
        raw_times_five = {1'b0, raw_cut_position, 2'b00} + {3'b000, raw_cut_position};
        eighth         = raw_times_five >> 3;
        cut_position   = raw_times_five + eighth; // roughly raw * 5.625
    end

endmodule

// File: line_rotator.sv
`timescale 1ns/100ps
`include "scrambler_macros.svh"

module line_rotator import scrambler_pkg::*; #(
    parameter int MODE = `MODE_SCRAMBLER
) (
    input  logic          clk,
    input  logic          reset_n,
    input  video_sample_t video_in,
    input  logic [7:0]    raw_cut_position,
    output logic [9:0]    data_out
);

    localparam line_addr_t LINE_SIZE = line_addr_t'(`ACTIVE_LINE_SIZE);
    localparam logic [`LINE_ADDR_BITS:0] LINE_SIZE_WIDE = `ACTIVE_LINE_SIZE;

    logic [9:0] line_buffer [0:1][0:`LINE_BUFFER_DEPTH-1]; // ping-pong line memory

    line_addr_t cut_position;
    line_addr_t write_index; // position inside the current line
    line_addr_t wr_idx;      // write index as seen this clock, 0 at line start
    line_addr_t rot_idx;     // wr_idx rotated by the cut
    line_addr_t wr_addr;
    line_addr_t rd_addr;

    logic [`LINE_ADDR_BITS:0] rot_sum; // one bit wider, the sum reaches 2873

    logic buf_sel;    // buffer being written during the line
    logic wr_sel;     // buffer written this clock
    logic prev_h;
    logic line_start; // falling edge of h

    cut_position_interpolator cut_position_interpolator_i (
        .raw_cut_position (raw_cut_position),
        .cut_position     (cut_position)
    );

    always_comb begin
        line_start = prev_h & ~video_in.h;
        wr_sel     = line_start ? ~buf_sel : buf_sel; // the swap takes effect on the edge itself
        wr_idx     = line_start ? '0 : write_index;
        rot_sum    = {1'b0, wr_idx} + {1'b0, cut_position};

        // rotate only inside the active window, blanking goes straight through
        if (wr_idx < LINE_SIZE && !video_in.h && !video_in.v) begin
            if (rot_sum < LINE_SIZE_WIDE) begin
                rot_idx = rot_sum[`LINE_ADDR_BITS-1:0];
            end else begin
                rot_idx = line_addr_t'(rot_sum - LINE_SIZE_WIDE); // wrap at 1440
            end
        end else begin
            rot_idx = wr_idx;
        end

        if (MODE == `MODE_SCRAMBLER) begin
            wr_addr = wr_idx;  // store in natural order
            rd_addr = rot_idx; // read rotated
        end else begin
            wr_addr = rot_idx; // undo the rotation while storing
            rd_addr = wr_idx;
        end
    end

    always_ff @(posedge clk) begin
        line_buffer[wr_sel][wr_addr] <= video_in.data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_sel  <= 1'b0;
            data_out <= '0;
            prev_h   <= video_in.h; // no false line start straight out of reset
            if (!video_in.h) begin
                write_index <= '0;
            end else begin
                write_index <= LINE_SIZE; // park in blanking until the next line
            end
        end else begin
            data_out    <= line_buffer[~wr_sel][rd_addr]; // the other buffer holds the previous line
            buf_sel     <= wr_sel;
            write_index <= wr_idx + 1'b1;
            prev_h      <= video_in.h;
        end
    end

endmodule

// File: line_scrambler_checker.sv
`timescale 1ns/100ps

module line_scrambler_checker import scrambler_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  video_sample_t scrambled_out,
    input  logic [9:0]    recovered_out,
    input  video_sample_t exp_scrambled,
    input  logic          check_scrambled,
    input  logic [9:0]    exp_recovered,
    input  logic          check_recovered,
    output int            active_checks,
    output int            blank_checks,
    output int            recovered_checks,
    output int            error_count
);

    localparam int PRINT_LIMIT = 20;

    video_sample_t scr_exp_q;    // lined up with the registered scrambler output
    logic          scr_check_q;
    logic [9:0]    rec_exp_q1;
    logic [9:0]    rec_exp_q2;   // recovered data trails the input by two clocks
    logic          rec_check_q1;
    logic          rec_check_q2;

    // the expectations arrive with the sample, so they are delayed to meet the outputs
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scr_exp_q    <= '0;
            scr_check_q  <= 1'b0;
            rec_exp_q1   <= '0;
            rec_exp_q2   <= '0;
            rec_check_q1 <= 1'b0;
            rec_check_q2 <= 1'b0;
        end else begin
            scr_exp_q    <= exp_scrambled;
            scr_check_q  <= check_scrambled;
            rec_exp_q1   <= exp_recovered;
            rec_exp_q2   <= rec_exp_q1;
            rec_check_q1 <= check_recovered;
            rec_check_q2 <= rec_check_q1;
        end
    end

    task automatic report_mismatch(input string name, input logic [9:0] got,
                                   input logic [9:0] expected);
        if (error_count < PRINT_LIMIT) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t ns", name, got, expected, $time);
        end else if (error_count == PRINT_LIMIT) begin
            $display("Too many errors, further mismatches are only counted");
        end
        error_count++;
    endtask

    // outputs change on the rising edge, so they are compared on the falling one
    always @(negedge clk) begin
        if (!reset_n) begin
            active_checks    = 0;
            blank_checks     = 0;
            recovered_checks = 0;
            error_count      = 0;
        end else begin
            if (scr_check_q) begin
                if (scr_exp_q.h || scr_exp_q.v) begin
                    blank_checks++; // passthrough of the previous line
                end else begin
                    active_checks++; // rotated read, covers the key sequence too
                end
                if (scrambled_out.data !== scr_exp_q.data) begin
                    report_mismatch("scrambled_out.data", scrambled_out.data, scr_exp_q.data);
                end
                if (scrambled_out.h !== scr_exp_q.h) begin
                    report_mismatch("scrambled_out.h", 10'(scrambled_out.h), 10'(scr_exp_q.h));
                end
                if (scrambled_out.v !== scr_exp_q.v) begin
                    report_mismatch("scrambled_out.v", 10'(scrambled_out.v), 10'(scr_exp_q.v));
                end
            end
            if (rec_check_q2) begin
                recovered_checks++;
                if (recovered_out !== rec_exp_q2) begin
                    report_mismatch("recovered_out", recovered_out, rec_exp_q2);
                end
            end
        end
    end

endmodule

// File: line_scrambler_tb.sv
`timescale 1ns/100ps
`include "scrambler_macros.svh"

module line_scrambler_tb import scrambler_pkg::*; ();

    localparam int BLANK_SIZE      = 288;
    localparam int LINE_TOTAL      = `ACTIVE_LINE_SIZE + BLANK_SIZE; // 1728 clocks per line
    localparam int V_LINES         = 2;                              // v high lines per frame
    localparam int LINES_PER_FRAME = 6;
    localparam int NUM_TESTS       = 4;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * LINES_PER_FRAME * LINE_TOTAL + 1000;

    logic          clk;
    logic          reset_n;
    video_sample_t video_in;
    logic [15:0]   seed;
    video_sample_t scrambled_out;
    logic [9:0]    recovered_out;

    video_sample_t exp_scrambled;   // expected scrambler output for the sample just driven
    logic          check_scrambled;
    logic [9:0]    exp_recovered;
    logic          check_recovered;

    int active_checks;
    int blank_checks;
    int recovered_checks;
    int error_count;

    logic [9:0]  line_store [0:2][0:LINE_TOTAL-1]; // the last three input lines by line_count mod 3
    int          line_count;                       // input lines driven since reset
    logic [15:0] ref_lfsr;
    logic [15:0] frame_seed;
    integer      rand_seed;

    line_scrambler_top line_scrambler_top_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .video_in      (video_in),
        .seed          (seed),
        .scrambled_out (scrambled_out),
        .recovered_out (recovered_out)
    );

    line_scrambler_checker line_scrambler_checker_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .scrambled_out    (scrambled_out),
        .recovered_out    (recovered_out),
        .exp_scrambled    (exp_scrambled),
        .check_scrambled  (check_scrambled),
        .exp_recovered    (exp_recovered),
        .check_recovered  (check_recovered),
        .active_checks    (active_checks),
        .blank_checks     (blank_checks),
        .recovered_checks (recovered_checks),
        .error_count      (error_count)
    );

    // taps x^16+x^14+x^13+x^11, shifting left
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic int scale_cut(input logic [7:0] raw);
        int times_five;
        times_five = int'(raw) * 5;
        return times_five + (times_five >> 3); // 255 lands on 1434
    endfunction

    function automatic int rotated_index(input int k, input int cut);
        return (k + cut) % `ACTIVE_LINE_SIZE;
    endfunction

    // drives one full line and the expected outputs that belong to each sample
    task automatic drive_line(input bit vertical);
        int            k;
        int            cut;
        int            cur;
        int            prev;
        int            older;
        logic [7:0]    raw;
        logic [31:0]   rand_word;
        video_sample_t sample;
        video_sample_t expected;
        if (vertical) begin
            ref_lfsr = frame_seed; // the key restarts from the seed during v
        end else begin
            ref_lfsr = lfsr_step(ref_lfsr);
        end
        raw   = ref_lfsr[7:0];
        cut   = scale_cut(raw);
        cur   = line_count % 3;
        prev  = (line_count + 2) % 3;
        older = (line_count + 1) % 3;
        for (k = 0; k < LINE_TOTAL; k++) begin
            @(posedge clk);
            rand_word   = $random(rand_seed);
            sample.data = rand_word[9:0];
            sample.h    = (k >= `ACTIVE_LINE_SIZE);
            sample.v    = vertical;
            line_store[cur][k] = sample.data;

            expected.h = sample.h;
            expected.v = sample.v;
            if (!sample.h && !sample.v) begin
                expected.data = line_store[prev][rotated_index(k, cut)];
            end else begin
                expected.data = line_store[prev][k]; // blanking reads the same index
            end

            video_in        <= sample;
            seed            <= frame_seed;
            exp_scrambled   <= expected;
            check_scrambled <= (line_count >= 1);
            exp_recovered   <= line_store[older][k];
            check_recovered <= (line_count >= 2);
        end
        line_count++;
    endtask

    task automatic run_test(input int number, input string name, input logic [15:0] test_seed,
                            input bit last);
        int active_before;
        int blank_before;
        int recovered_before;
        int errors_before;
        int line_idx;
        active_before    = active_checks;
        blank_before     = blank_checks;
        recovered_before = recovered_checks;
        errors_before    = error_count;
        frame_seed       = test_seed;
        for (line_idx = 0; line_idx < LINES_PER_FRAME; line_idx++) begin
            drive_line(line_idx < V_LINES);
        end
        if (last) begin
            // let the two-clock recovery path drain
            @(posedge clk);
            check_scrambled <= 1'b0;
            check_recovered <= 1'b0;
            repeat (2) @(posedge clk);
        end
        $display("test %0d %s (seed 0x%h): %0d active, %0d blanking, %0d recovered, %0d errors",
                 number, name, test_seed, active_checks - active_before,
                 blank_checks - blank_before, recovered_checks - recovered_before,
                 error_count - errors_before);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rand_seed       = 32'he9a;
        reset_n         = 1'b0;
        video_in        = '0;
        video_in.h      = 1'b1; // start in blanking so the first line has a clean h edge
        video_in.v      = 1'b1;
        seed            = 16'hace1;
        exp_scrambled   = '0;
        check_scrambled = 1'b0;
        exp_recovered   = '0;
        check_recovered = 1'b0;
        line_count      = 0;
        ref_lfsr        = '0;
        frame_seed      = 16'hace1;

        repeat (16) @(posedge clk);
        reset_n <= 1'b1;

        run_test(1, "random seed", 16'hace1, 1'b0);
        run_test(2, "raw cut 0", 16'h3000, 1'b0);   // first step gives 0x6000
        run_test(3, "raw cut 255", 16'h807f, 1'b0); // first step gives 0x00ff and a cut of 1434
        run_test(4, "second random seed", 16'h5a3c, 1'b1);

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS,
                 active_checks + blank_checks + recovered_checks, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: line_scrambler_top.sv
`timescale 1ns/100ps
`include "scrambler_macros.svh"

module line_scrambler_top import scrambler_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  video_sample_t video_in,
    input  logic [15:0]   seed,
    output video_sample_t scrambled_out,
    output logic [9:0]    recovered_out
);

    logic [7:0] raw_cut;
    logic [7:0] raw_cut_delayed;
    logic [9:0] scrambled_data;
    logic       h_q; // h and v delayed to line up with the registered rotator output
    logic       v_q;

    cut_key_generator cut_key_generator_i (
        .clk             (clk),
        .reset_n         (reset_n),
        .video_in        (video_in),
        .seed            (seed),
        .raw_cut         (raw_cut),
        .raw_cut_delayed (raw_cut_delayed)
    );

    line_rotator #(
        .MODE (`MODE_SCRAMBLER)
    ) scrambler_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .video_in         (video_in),
        .raw_cut_position (raw_cut),
        .data_out         (scrambled_data)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h_q <= 1'b0;
            v_q <= 1'b0;
        end else begin
            h_q <= video_in.h;
            v_q <= video_in.v;
        end
    end

    always_comb begin
        scrambled_out.data = scrambled_data;
        scrambled_out.h    = h_q;
        scrambled_out.v    = v_q;
    end

    // The descrambler runs on the scrambled stream and its timing
    line_rotator #(
        .MODE (`MODE_DESCRAMBLER)
    ) descrambler_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .video_in         (scrambled_out),
        .raw_cut_position (raw_cut_delayed),
        .data_out         (recovered_out)
    );

endmodule

// File: scrambler_macros.svh
`ifndef SCRAMBLER_MACROS_SVH
`define SCRAMBLER_MACROS_SVH

// 720 luma/chroma pairs per active line
`define ACTIVE_LINE_SIZE 1440

// each line buffer is a power of two deep, so blanking samples fit behind the active part
`define LINE_BUFFER_DEPTH 2048

// enough to address LINE_BUFFER_DEPTH samples
`define LINE_ADDR_BITS 11

// line rotator modes
`define MODE_SCRAMBLER 0
`define MODE_DESCRAMBLER 1

`endif

// File: scrambler_pkg.sv
`include "scrambler_macros.svh"

package scrambler_pkg;

    // one 10-bit video sample with its blanking flags
    typedef struct packed {
        logic [9:0] data; // luma or chroma value
        logic       h;    // horizontal blanking, high during blanking
        logic       v;    // vertical blanking
    } video_sample_t;

    // sample position inside one line buffer
    typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;

endpackage

// File: src.f
+incdir+.
scrambler_pkg.sv
cut_position_interpolator.sv
line_rotator.sv
cut_key_generator.sv
line_scrambler_top.sv
line_scrambler_checker.sv
line_scrambler_tb.sv
